// File: Bender.yml
package:
  name: rd_sys

sources:
  - design/rd_bus_pkg.sv
  - design/rd_arbiter.sv
  - design/axi_rd_master.sv
  - design/rd_sys_top.sv
  - target: test
    files:
      - testbench/tb_axi_rd_slave.sv
      - testbench/tb_rd_sys.sv

// File: design/axi_rd_master.sv
`timescale 1ns/1ns

module axi_rd_master import rd_bus_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    // grant side
    input  logic    gnt_valid_i,
    input  rd_req_t gnt_req_i,
    input  axi_id_t gnt_id_i,
    output logic    gnt_ready_o,
    output logic    res_valid_o,
    output rd_rsp_t res_o,
    output axi_id_t res_id_o,
    input  logic    res_ready_i,
    // axi read port
    output logic    ar_valid_o,
    output axi_ar_t ar_o,
    input  logic    ar_ready_i,
    input  logic    r_valid_i,
    input  axi_r_t  r_i,
    output logic    r_ready_o
);

    mst_state_e state_q, state_d;

    rd_req_t req_q;   // latched on grant
    axi_id_t id_q;
    rd_rsp_t rsp_q;

    logic [BYTES_W-1:0] offset;
    logic [BYTES_W+2:0] shamt;   // offset in bits
    data_t              lane;
    logic               r_hit;   // final beat accepted

    // byte count to axi size code
    function automatic logic [2:0] axi_size(input size_t sz);
        case (sz)
            8'd1:    axi_size = 3'd0;
            8'd2:    axi_size = 3'd1;
            8'd4:    axi_size = 3'd2;
            default: axi_size = 3'd3;
        endcase
    endfunction

    // keep the low sz bytes
    function automatic data_t lane_mask(input size_t sz);
        case (sz)
            8'd1:    lane_mask = 64'h0000_0000_0000_00ff;
            8'd2:    lane_mask = 64'h0000_0000_0000_ffff;
            8'd4:    lane_mask = 64'h0000_0000_ffff_ffff;
            default: lane_mask = '1;
        endcase
    endfunction

    assign r_hit = r_valid_i & r_ready_o & r_i.last;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            M_IDLE: if (gnt_valid_i) state_d = M_AR;
            M_AR:   if (ar_ready_i)  state_d = M_R;
            M_R:    if (r_hit)       state_d = M_RSP;
            M_RSP:  if (res_ready_i) state_d = M_IDLE;
            default: state_d = M_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i)
            state_q <= M_IDLE;
        else
            state_q <= state_d;
    end

    // handshake outputs straight from state
    assign gnt_ready_o = (state_q == M_IDLE);
    assign ar_valid_o  = (state_q == M_AR);
    assign r_ready_o   = (state_q == M_R);
    assign res_valid_o = (state_q == M_RSP);

    // single beat, word aligned
    assign ar_o.id    = id_q;
    assign ar_o.addr  = {req_q.addr[ADDR_W-1:BYTES_W], {BYTES_W{1'b0}}};
    assign ar_o.len   = 8'd0;
    assign ar_o.size  = axi_size(req_q.size);
    assign ar_o.burst = AXI_BURST_INCR;

    // move the addressed bytes down to bit 0
    assign offset = req_q.addr[BYTES_W-1:0];
    assign shamt  = {offset, 3'b000};
    assign lane   = (r_i.data >> shamt) & lane_mask(req_q.size);

    always_ff @(posedge clk) begin
        if (gnt_valid_i && gnt_ready_o) begin
            req_q <= gnt_req_i;
            id_q  <= gnt_id_i;
        end
        if (r_hit) begin
            rsp_q.data <= lane;
            rsp_q.err  <= (r_i.resp != AXI_RESP_OKAY);   // slverr or decerr
        end
    end

    assign res_o    = rsp_q;
    assign res_id_o = id_q;

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

    // slave sends one beat per read and echoes our id
    a_r_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        r_valid_i && r_ready_o |-> r_i.last && (r_i.id == id_q));

    a_gnt_size: assert property (@(posedge clk) disable iff (!rst_n_i)
        gnt_valid_i && gnt_ready_o |-> gnt_req_i.size inside {8'd1, 8'd2, 8'd4, 8'd8});

endmodule

// File: design/rd_arbiter.sv
`timescale 1ns/1ns

module rd_arbiter import rd_bus_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    // mem stage port
    input  logic    mem_req_valid_i,
    input  rd_req_t mem_req_i,
    output logic    mem_req_ready_o,
    output logic    mem_rsp_valid_o,
    output rd_rsp_t mem_rsp_o,
    input  logic    mem_rsp_ready_i,
    // fetch stage port
    input  logic    if_req_valid_i,
    input  rd_req_t if_req_i,
    output logic    if_req_ready_o,
    output logic    if_rsp_valid_o,
    output rd_rsp_t if_rsp_o,
    input  logic    if_rsp_ready_i,
    // towards the axi master
    output logic    gnt_valid_o,
    output rd_req_t gnt_req_o,
    output axi_id_t gnt_id_o,
    input  logic    gnt_ready_i,
    input  logic    res_valid_i,
    input  rd_rsp_t res_i,
    input  axi_id_t res_id_i,
    output logic    res_ready_o
);

    rd_owner_e owner_q, owner_d;
    logic      own_mem, own_if;
    logic      res_done;   // response handshake with the owner

    assign own_mem  = (owner_q == OWN_MEM);
    assign own_if   = (owner_q == OWN_IF);
    assign res_done = res_valid_i & res_ready_o;

    // mem first, grant held until its response is taken
    always_comb begin
        owner_d = owner_q;
        unique case (owner_q)
            OWN_NONE: begin
                if (mem_req_valid_i)
                    owner_d = OWN_MEM;
                else if (if_req_valid_i)
                    owner_d = OWN_IF;
            end
            OWN_MEM, OWN_IF: begin
                if (res_done)
                    owner_d = OWN_NONE;   // free again next cycle
            end
            default: owner_d = OWN_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i)
            owner_q <= OWN_NONE;
        else
            owner_q <= owner_d;
    end

    // request path, only the owner reaches the master
    assign gnt_valid_o = (own_mem & mem_req_valid_i) | (own_if & if_req_valid_i);
    assign gnt_req_o   = own_if ? if_req_i : mem_req_i;
    assign gnt_id_o    = own_if ? IF_ID : MEM_ID;

    assign mem_req_ready_o = own_mem & gnt_ready_i;
    assign if_req_ready_o  = own_if & gnt_ready_i;

    // response path
    assign mem_rsp_valid_o = own_mem & res_valid_i;
    assign if_rsp_valid_o  = own_if & res_valid_i;
    assign mem_rsp_o       = res_i;   // payload shared, valid tells who
    assign if_rsp_o        = res_i;
    assign res_ready_o     = (own_mem & mem_rsp_ready_i) | (own_if & if_rsp_ready_i);

    a_rsp_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mem_rsp_valid_o && if_rsp_valid_o));

    // master must echo the id it was handed with the grant
    a_res_id: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_i |-> (owner_q != OWN_NONE) && (res_id_i == gnt_id_o));

    // a pending response holds still and keeps its owner
    a_hold_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_i && !res_ready_o |=> res_valid_i && $stable(res_i) && $stable(owner_q));

endmodule

// File: design/rd_bus_pkg.sv
package rd_bus_pkg;

    localparam int ADDR_W  = 64;
    localparam int DATA_W  = 64;
    localparam int ID_W    = 4;
    localparam int BYTES_W = 3;   // byte offset within one data word

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [7:0]        size_t;    // byte count 1/2/4/8
    typedef logic [ID_W-1:0]   axi_id_t;

    localparam axi_id_t MEM_ID = 4'd1;    // owner tag on the AR/R channels
    localparam axi_id_t IF_ID  = 4'd0;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

    typedef struct packed {
        addr_t addr;
        size_t size;
    } rd_req_t;   // 72 bits

    typedef struct packed {
        data_t data;
        logic  err;   // resp was not OKAY
    } rd_rsp_t;   // 65 bits

    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        axi_id_t    id;
        data_t      data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    typedef enum logic [1:0] {OWN_NONE, OWN_MEM, OWN_IF} rd_owner_e;

    typedef enum logic [1:0] {M_IDLE, M_AR, M_R, M_RSP} mst_state_e;

endpackage

// File: design/rd_sys_top.sv
`timescale 1ns/1ns

module rd_sys_top import rd_bus_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    // mem stage
    input  logic    mem_req_valid_i,
    input  rd_req_t mem_req_i,
    output logic    mem_req_ready_o,
    output logic    mem_rsp_valid_o,
    output rd_rsp_t mem_rsp_o,
    input  logic    mem_rsp_ready_i,
    // fetch stage
    input  logic    if_req_valid_i,
    input  rd_req_t if_req_i,
    output logic    if_req_ready_o,
    output logic    if_rsp_valid_o,
    output rd_rsp_t if_rsp_o,
    input  logic    if_rsp_ready_i,
    // external axi read port
    output logic    ar_valid_o,
    output axi_ar_t ar_o,
    input  logic    ar_ready_i,
    input  logic    r_valid_i,
    input  axi_r_t  r_i,
    output logic    r_ready_o
);

    // arbiter <-> master
    logic    gnt_valid, gnt_ready;
    rd_req_t gnt_req;
    axi_id_t gnt_id;
    logic    res_valid, res_ready;
    rd_rsp_t res;
    axi_id_t res_id;

    rd_arbiter u_arb (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .mem_req_valid_i (mem_req_valid_i),
        .mem_req_i       (mem_req_i),
        .mem_req_ready_o (mem_req_ready_o),
        .mem_rsp_valid_o (mem_rsp_valid_o),
        .mem_rsp_o       (mem_rsp_o),
        .mem_rsp_ready_i (mem_rsp_ready_i),
        .if_req_valid_i  (if_req_valid_i),
        .if_req_i        (if_req_i),
        .if_req_ready_o  (if_req_ready_o),
        .if_rsp_valid_o  (if_rsp_valid_o),
        .if_rsp_o        (if_rsp_o),
        .if_rsp_ready_i  (if_rsp_ready_i),
        .gnt_valid_o     (gnt_valid),
        .gnt_req_o       (gnt_req),
        .gnt_id_o        (gnt_id),
        .gnt_ready_i     (gnt_ready),
        .res_valid_i     (res_valid),
        .res_i           (res),
        .res_id_i        (res_id),
        .res_ready_o     (res_ready)
    );

    axi_rd_master u_mst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .gnt_valid_i (gnt_valid),
        .gnt_req_i   (gnt_req),
        .gnt_id_i    (gnt_id),
        .gnt_ready_o (gnt_ready),
        .res_valid_o (res_valid),
        .res_o       (res),
        .res_id_o    (res_id),
        .res_ready_i (res_ready),
        .ar_valid_o  (ar_valid_o),
        .ar_o        (ar_o),
        .ar_ready_i  (ar_ready_i),
        .r_valid_i   (r_valid_i),
        .r_i         (r_i),
        .r_ready_o   (r_ready_o)
    );

endmodule

// File: list.f
design/rd_bus_pkg.sv
design/rd_arbiter.sv
design/axi_rd_master.sv
design/rd_sys_top.sv
testbench/tb_axi_rd_slave.sv
testbench/tb_rd_sys.sv

// File: testbench/tb_axi_rd_slave.sv
`timescale 1ns/1ns

module tb_axi_rd_slave import rd_bus_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    ar_valid_i,
    input  axi_ar_t ar_i,
    output logic    ar_ready_o,
    output logic    r_valid_o,
    output axi_r_t  r_o,
    input  logic    r_ready_i
);

    data_t       mem [64];   // word store, index from addr[8:3]
    logic [31:0] lfsr = 32'h35d3_f36e;
    int          err_cnt = 0;

    // galois lfsr, one step per bit taken
    function automatic logic lfsr_bit();
        lfsr_bit = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // 0..3 cycles, two bits
    function automatic int delay2();
        logic [1:0] d;
        d[1] = lfsr_bit();
        d[0] = lfsr_bit();
        delay2 = d;
    endfunction

    initial begin
        for (int w = 0; w < 64; w++)
            for (int b = 0; b < DATA_W; b++)
                mem[w][b] = lfsr_bit();
    end

    initial begin
        axi_id_t    id;
        logic [5:0] idx;
        int         n;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_o        = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n_i && ar_valid_i) begin
                repeat (delay2()) begin
                    @(posedge clk);
                    #1;
                end
                id         = ar_i.id;
                idx        = ar_i.addr[8:3];
                ar_ready_o = 1'b1;   // valid is held, handshake on next edge
                @(posedge clk);
                #1;
                ar_ready_o = 1'b0;
                repeat (delay2()) begin
                    @(posedge clk);
                    #1;
                end
                r_o.id    = id;   // echo for routing
                r_o.data  = mem[idx];
                r_o.resp  = (idx == 6'd63) ? 2'b10 : 2'b00;   // slverr on last word
                r_o.last  = 1'b1;
                r_valid_o = 1'b1;
                n = 0;
                while (!r_ready_i && n < 100) begin
                    @(posedge clk);
                    #1;
                    n++;
                end
                if (n >= 100) begin
                    $display("slave: r_ready never rose at %0t", $time);
                    err_cnt++;
                end
                @(posedge clk);
                #1;
                r_valid_o = 1'b0;
            end
        end
    end

endmodule

// File: testbench/tb_rd_sys.sv
`timescale 1ns/1ns

module tb_rd_sys import rd_bus_pkg::*;;

    localparam int TMO   = 100;   // cycles per wait
    localparam int NROWS = 16;

    typedef struct packed {
        logic       mem_v;
        addr_t      mem_addr;
        size_t      mem_size;
        logic       if_v;
        addr_t      if_addr;
        size_t      if_size;
        logic [3:0] mem_hold;   // rsp_ready hold-off cycles
        logic [3:0] if_hold;
    } row_t;

    logic    clk = 1'b0;
    logic    rst_n_i;
    logic    mem_req_valid_i, mem_req_ready_o, mem_rsp_valid_o, mem_rsp_ready_i;
    logic    if_req_valid_i, if_req_ready_o, if_rsp_valid_o, if_rsp_ready_i;
    rd_req_t mem_req_i, if_req_i;
    rd_rsp_t mem_rsp_o, if_rsp_o;
    logic    ar_valid_o, ar_ready_i, r_valid_i, r_ready_o;
    axi_ar_t ar_o;
    axi_r_t  r_i;

    row_t rows [NROWS];
    int   errors = 0;
    int   total;
    time  t_mem, t_if;

    always #4 clk = ~clk;

    rd_sys_top UUT (.*);

    tb_axi_rd_slave u_slave (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ar_valid_i (ar_valid_o),
        .ar_i       (ar_o),
        .ar_ready_o (ar_ready_i),
        .r_valid_o  (r_valid_i),
        .r_o        (r_i),
        .r_ready_i  (r_ready_o)
    );

    task automatic check(input string name, input logic [127:0] exp,
                         input logic [127:0] act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // word from the store, moved down by the byte offset, cut to size bytes
    function automatic data_t expect_data(input addr_t a, input size_t sz);
        data_t w;
        w = u_slave.mem[a[8:3]] >> (8 * a[2:0]);
        if (sz < 8)
            w = w & ((64'h1 << (8 * sz)) - 1);
        return w;
    endfunction

    task automatic set_req(input logic is_mem, input logic v, input addr_t a, input size_t sz);
        if (is_mem) begin
            mem_req_valid_i = v;
            mem_req_i       = '{addr: a, size: sz};
        end else begin
            if_req_valid_i = v;
            if_req_i       = '{addr: a, size: sz};
        end
    endtask

    // one read on one port, from request to response handshake
    task automatic run_port(input logic is_mem, input addr_t a, input size_t sz,
                            input int hold, output time t_done);
        string   pn;
        rd_rsp_t snap;
        axi_ar_t exp_ar;
        int      n;
        pn = is_mem ? "mem" : "if";
        t_done = 0;
        set_req(is_mem, 1'b1, a, sz);
        n = 0;
        while (!(is_mem ? mem_req_ready_o : if_req_ready_o) && n < TMO) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= TMO) begin
            $display("timeout: %s request at %h was never accepted", pn, a);
            errors++;
            set_req(is_mem, 1'b0, '0, '0);
            return;
        end
        @(posedge clk);
        #1;
        set_req(is_mem, 1'b0, '0, '0);
        // ar beat one cycle after acceptance, single incr beat on the word
        exp_ar = '{id: (is_mem ? MEM_ID : IF_ID), addr: (a & ~64'h7), len: 8'd0,
                   size: $clog2(sz), burst: 2'b01};
        check("ar_valid_o", 1, ar_valid_o);
        check("ar_o", exp_ar, ar_o);
        n = 0;
        while (!(is_mem ? mem_rsp_valid_o : if_rsp_valid_o) && n < TMO) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= TMO) begin
            $display("timeout: %s response for %h never came", pn, a);
            errors++;
            return;
        end
        snap = is_mem ? mem_rsp_o : if_rsp_o;
        repeat (hold) begin   // back-pressure, all must hold still
            check({pn, "_rsp_valid_o"}, 1, is_mem ? mem_rsp_valid_o : if_rsp_valid_o);
            check({pn, "_rsp_o"}, snap, is_mem ? mem_rsp_o : if_rsp_o);
            check("other req_ready_o", 0, is_mem ? if_req_ready_o : mem_req_ready_o);
            check("other rsp_valid_o", 0, is_mem ? if_rsp_valid_o : mem_rsp_valid_o);
            @(posedge clk);
            #1;
        end
        check("other rsp_valid_o", 0, is_mem ? if_rsp_valid_o : mem_rsp_valid_o);
        check({pn, "_rsp_o.data"}, expect_data(a, sz),
              is_mem ? mem_rsp_o.data : if_rsp_o.data);
        check({pn, "_rsp_o.err"}, a[8:3] == 6'd63, is_mem ? mem_rsp_o.err : if_rsp_o.err);
        if (is_mem)
            mem_rsp_ready_i = 1'b1;
        else
            if_rsp_ready_i = 1'b1;
        t_done = $time;
        @(posedge clk);
        #1;
        if (is_mem)
            mem_rsp_ready_i = 1'b0;
        else
            if_rsp_ready_i = 1'b0;
    endtask

    initial begin
        // single reads, every size on both ports
        rows[0]  = '{0, 64'h0,   8'd0, 1, 64'h08,  8'd8, 4'd0, 4'd0};
        rows[1]  = '{1, 64'h13,  8'd1, 0, 64'h0,   8'd0, 4'd0, 4'd0};
        rows[2]  = '{0, 64'h0,   8'd0, 1, 64'h26,  8'd2, 4'd0, 4'd0};
        rows[3]  = '{1, 64'h34,  8'd4, 0, 64'h0,   8'd0, 4'd0, 4'd0};
        rows[4]  = '{1, 64'h40,  8'd8, 0, 64'h0,   8'd0, 4'd0, 4'd0};
        rows[5]  = '{0, 64'h0,   8'd0, 1, 64'h57,  8'd1, 4'd0, 4'd0};
        rows[6]  = '{0, 64'h0,   8'd0, 1, 64'h64,  8'd4, 4'd0, 4'd0};
        rows[7]  = '{1, 64'h7a,  8'd2, 0, 64'h0,   8'd0, 4'd0, 4'd0};
        // same-cycle requests, mem goes first
        rows[8]  = '{1, 64'h80,  8'd8, 1, 64'h94,  8'd4, 4'd0, 4'd0};
        rows[9]  = '{1, 64'ha2,  8'd2, 1, 64'hb8,  8'd8, 4'd6, 4'd3};   // rsp_ready held off
        rows[10] = '{1, 64'h1f8, 8'd8, 1, 64'h1fc, 8'd4, 4'd0, 4'd2};   // word 63
        // back-to-back series
        rows[11] = '{1, 64'hc4,  8'd4, 1, 64'hd0,  8'd8, 4'd0, 4'd0};
        rows[12] = '{1, 64'he1,  8'd1, 1, 64'hf6,  8'd2, 4'd1, 4'd0};
        rows[13] = '{1, 64'h108, 8'd8, 1, 64'h11c, 8'd4, 4'd0, 4'd1};
        rows[14] = '{1, 64'h12e, 8'd2, 1, 64'h13f, 8'd1, 4'd0, 4'd0};
        rows[15] = '{1, 64'h150, 8'd4, 1, 64'h168, 8'd8, 4'd2, 4'd0};

        rst_n_i         = 1'b0;
        mem_req_valid_i = 1'b0;
        mem_req_i       = '0;
        mem_rsp_ready_i = 1'b0;
        if_req_valid_i  = 1'b0;
        if_req_i        = '0;
        if_rsp_ready_i  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        repeat (10) begin   // idle bus after reset
            check("mem_req_ready_o", 0, mem_req_ready_o);
            check("if_req_ready_o", 0, if_req_ready_o);
            check("mem_rsp_valid_o", 0, mem_rsp_valid_o);
            check("if_rsp_valid_o", 0, if_rsp_valid_o);
            check("ar_valid_o", 0, ar_valid_o);
            check("r_ready_o", 0, r_ready_o);
            @(posedge clk);
            #1;
        end

        for (int i = 0; i < NROWS; i++) begin
            fork
                if (rows[i].mem_v)
                    run_port(1'b1, rows[i].mem_addr, rows[i].mem_size, rows[i].mem_hold, t_mem);
                if (rows[i].if_v)
                    run_port(1'b0, rows[i].if_addr, rows[i].if_size, rows[i].if_hold, t_if);
            join
            if (rows[i].mem_v && rows[i].if_v)
                check("mem response first", 1, t_mem < t_if);
        end

        total = errors + u_slave.err_cnt;
        $display("errors: %0d (testbench %0d, slave %0d)", total, errors, u_slave.err_cnt);
        if (total == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule
